//--- Bender.yml
package:
  name: mult_16x16

sources:
  - src/dadda_pkg.sv
  - src/pp_gen.sv
  - src/dadda_stage.sv
  - src/dadda_tree.sv
  - src/prefix_adder.sv
  - src/mult_16x16.sv
  - target: test
    files:
      - testbench/mult_checker.sv
      - testbench/tb_mult_16x16.sv

//--- build.f
src/dadda_pkg.sv
src/pp_gen.sv
src/dadda_stage.sv
src/dadda_tree.sv
src/prefix_adder.sv
src/mult_16x16.sv
testbench/mult_checker.sv
testbench/tb_mult_16x16.sv

//--- src/dadda_pkg.sv
package dadda_pkg;

  // Operand and product widths
  localparam int op_width   = 16;
  localparam int prod_width = 2 * op_width;

  // Tallest column of the partial-product array
  localparam int max_height = op_width;

  localparam int num_levels = 6;

  // The matrix is 6 high after this level and gets registered there
  localparam int mid_level  = 3;

  // Target heights, one per reduction level
  localparam int dadda_heights [num_levels] = '{13, 9, 6, 4, 3, 2};

  // Row r, bit c holds the r-th dot of weight c
  typedef logic [max_height-1:0][prod_width-1:0] dot_matrix_t;

  typedef logic [1:0][prod_width-1:0] two_rows_t;

  // Number of partial products of weight c
  function automatic int column_height(int c);
    if (c < 0 || c >= prod_width) begin
      return 0;
    end
    if (c < op_width) begin
      return c + 1;
    end
    return prod_width - 1 - c;
  endfunction

endpackage

//--- src/dadda_stage.sv
`timescale 1ns/1ps

module dadda_stage import dadda_pkg::*; #(
  parameter int in_height     = max_height,
  parameter int target_height = 13
) (
  input  dot_matrix_t dots_in,
  output dot_matrix_t dots_out
);

  // Replays the reduction from the initial array up to this level
  // kind 0 gives the incoming column height, 1 the full adders, 2 the half adders
  function automatic int col_info(int col, int kind);
    int h [prod_width];
    int carry;
    int excess;
    int fa_cnt;
    int ha_cnt;
    int res;
    res = 0;
    for (int c = 0; c < prod_width; c++) begin
      h[c] = column_height(c);
    end
    for (int l = 0; l < num_levels; l++) begin
      if (dadda_heights[l] >= in_height || dadda_heights[l] == target_height) begin
        carry = 0;
        for (int c = 0; c < prod_width; c++) begin
          excess = h[c] + carry - dadda_heights[l];
          fa_cnt = (excess > 0) ? excess / 2 : 0;
          ha_cnt = (excess > 0) ? excess % 2 : 0;
          if (dadda_heights[l] == target_height && c == col) begin
            res = (kind == 0) ? h[c] : (kind == 1) ? fa_cnt : ha_cnt;
          end
          h[c] = h[c] + carry - 2 * fa_cnt - ha_cnt;
          carry = fa_cnt + ha_cnt;
        end
      end
    end
    return res;
  endfunction

  logic [max_height-1:0] col_out   [prod_width];
  logic [max_height-1:0] carry_out [prod_width];
  logic [max_height-1:0] carry_in  [prod_width];

  for (genvar c = 0; c < prod_width; c++) begin : g_col
    localparam int h_in   = col_info(c, 0);
    localparam int n_fa   = col_info(c, 1);
    localparam int n_ha   = col_info(c, 2);
    localparam int n_cin  = col_info(c - 1, 1) + col_info(c - 1, 2);
    localparam int n_add  = n_fa + n_ha;
    localparam int n_pass = h_in - 3 * n_fa - 2 * n_ha;

    if (c == 0) begin : g_lsb
      assign carry_in[c] = '0;
    end else begin : g_upper
      assign carry_in[c] = carry_out[c-1];
    end

    // New column holds sums first, then untouched dots, then carries from below
    always_comb begin
      col_out[c]   = '0;
      carry_out[c] = '0;
      for (int k = 0; k < n_fa; k++) begin
        col_out[c][k] = dots_in[3*k][c] ^ dots_in[3*k+1][c] ^ dots_in[3*k+2][c];
        carry_out[c][k] = (dots_in[3*k][c] & dots_in[3*k+1][c]) |
                          (dots_in[3*k+2][c] & (dots_in[3*k][c] ^ dots_in[3*k+1][c]));
      end
      for (int k = 0; k < n_ha; k++) begin
        col_out[c][n_fa+k]   = dots_in[3*n_fa+2*k][c] ^ dots_in[3*n_fa+2*k+1][c];
        carry_out[c][n_fa+k] = dots_in[3*n_fa+2*k][c] & dots_in[3*n_fa+2*k+1][c];
      end
      for (int k = 0; k < n_pass; k++) begin
        col_out[c][n_add+k] = dots_in[3*n_fa+2*n_ha+k][c];
      end
      for (int k = 0; k < n_cin; k++) begin
        col_out[c][n_add+n_pass+k] = carry_in[c][k];
      end
    end
  end

  // Back from columns to rows
  always_comb begin
    for (int r = 0; r < max_height; r++) begin
      for (int c = 0; c < prod_width; c++) begin
        dots_out[r][c] = col_out[c][r];
      end
    end
  end

endmodule

//--- src/dadda_tree.sv
`timescale 1ns/1ps

module dadda_tree import dadda_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        mid_load,
  input  dot_matrix_t dots,
  output two_rows_t   rows
);

  function automatic int level_in_height(int l);
    if (l == 0) begin
      return max_height;
    end
    return dadda_heights[l-1];
  endfunction

  dot_matrix_t lvl_in  [num_levels];
  dot_matrix_t lvl_out [num_levels];
  dot_matrix_t mid_q;

  //////////////////////////////
  // Reduction levels

  for (genvar l = 0; l < num_levels; l++) begin : g_level
    if (l == 0) begin : g_first
      assign lvl_in[l] = dots;
    end else if (l == mid_level) begin : g_after_reg
      assign lvl_in[l] = mid_q;
    end else begin : g_chain
      assign lvl_in[l] = lvl_out[l-1];
    end

    dadda_stage #(
      .in_height    (level_in_height(l)),
      .target_height(dadda_heights[l])
    ) i_dadda_stage (
      .dots_in (lvl_in[l]),
      .dots_out(lvl_out[l])
    );
  end

  //////////////////////////////
  // Register at the 6-high point

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mid_q <= '0;
    end else if (mid_load) begin
      mid_q <= lvl_out[mid_level-1];
    end
  end

  // Only the two lowest rows can still hold dots
  assign rows[0] = lvl_out[num_levels-1][0];
  assign rows[1] = lvl_out[num_levels-1][1];

endmodule

//--- src/mult_16x16.sv
`timescale 1ns/1ps

module mult_16x16 import dadda_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [op_width-1:0]   in_a,
  input  logic [op_width-1:0]   in_b,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [prod_width-1:0] out_product
);

  // Slot 0 operands, slot 1 tree middle, slot 2 product
  logic [2:0] slot_valid;
  logic       load0;
  logic       load1;
  logic       load2;
  logic       mid_load;

  logic [op_width-1:0]   a_q;
  logic [op_width-1:0]   b_q;
  logic [prod_width-1:0] product_q;

  dot_matrix_t           pp_dots;
  two_rows_t             tree_rows;
  logic [prod_width-1:0] sum;

  //////////////////////////////
  // Slot control

  // A slot takes new data when empty or when its content moves on
  assign load2 = !slot_valid[2] || out_ready;
  assign load1 = !slot_valid[1] || load2;
  assign load0 = !slot_valid[0] || load1;

  assign in_ready = load0;
  assign mid_load = load1 && slot_valid[0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot_valid <= '0;
    end else begin
      if (load0) begin
        slot_valid[0] <= in_valid;
      end
      if (load1) begin
        slot_valid[1] <= slot_valid[0];
      end
      if (load2) begin
        slot_valid[2] <= slot_valid[1];
      end
    end
  end

  //////////////////////////////
  // Datapath

  always_ff @(posedge clk) begin
    if (load0 && in_valid) begin
      a_q <= in_a;
      b_q <= in_b;
    end
  end

  pp_gen i_pp_gen (
    .a   (a_q),
    .b   (b_q),
    .dots(pp_dots)
  );

  dadda_tree i_dadda_tree (
    .clk     (clk),
    .rst_n   (rst_n),
    .mid_load(mid_load),
    .dots    (pp_dots),
    .rows    (tree_rows)
  );

  prefix_adder i_prefix_adder (
    .rows(tree_rows),
    .sum (sum)
  );

  // Held while the sink stalls
  always_ff @(posedge clk) begin
    if (load2 && slot_valid[1]) begin
      product_q <= sum;
    end
  end

  assign out_valid   = slot_valid[2];
  assign out_product = product_q;

endmodule

//--- src/pp_gen.sv
`timescale 1ns/1ps

module pp_gen import dadda_pkg::*; (
  input  logic [op_width-1:0] a,
  input  logic [op_width-1:0] b,
  output dot_matrix_t         dots
);

  // Dot a[i]&b[j] lands in column i+j
  // Low columns stack by i, high columns by the distance of j from the top
  always_comb begin
    dots = '0;
    for (int i = 0; i < op_width; i++) begin
      for (int j = 0; j < op_width; j++) begin
        if (i + j < op_width) begin
          dots[i][i+j] = a[i] & b[j];
        end else begin
          dots[op_width-1-j][i+j] = a[i] & b[j];
        end
      end
    end
  end

endmodule

//--- src/prefix_adder.sv
`timescale 1ns/1ps

module prefix_adder import dadda_pkg::*; (
  input  two_rows_t             rows,
  output logic [prod_width-1:0] sum
);

  localparam int ks_levels = $clog2(prod_width);

  logic [prod_width-1:0] gen  [ks_levels+1];
  logic [prod_width-1:0] prop [ks_levels+1];

  // Bitwise generate and propagate
  assign gen[0]  = rows[0] & rows[1];
  assign prop[0] = rows[0] ^ rows[1];

  //////////////////////////////
  // Kogge-Stone prefix levels

  for (genvar l = 0; l < ks_levels; l++) begin : g_level
    localparam int span = 1 << l;

    always_comb begin
      for (int i = 0; i < prod_width; i++) begin
        if (i >= span) begin
          gen[l+1][i]  = gen[l][i] | (prop[l][i] & gen[l][i-span]);
          prop[l+1][i] = prop[l][i] & prop[l][i-span];
        end else begin
          gen[l+1][i]  = gen[l][i];
          prop[l+1][i] = prop[l][i];
        end
      end
    end
  end

  // Carry into bit i is the group generate of bits i-1 down to 0
  assign sum = prop[0] ^ {gen[ks_levels][prod_width-2:0], 1'b0};

endmodule

//--- testbench/mult_checker.sv
`timescale 1ns/1ps

module mult_checker import dadda_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic                  in_ready,
  input  logic [op_width-1:0]   in_a,
  input  logic [op_width-1:0]   in_b,
  input  logic                  out_valid,
  input  logic                  out_ready,
  input  logic [prod_width-1:0] out_product,
  input  int                    test_id,
  input  logic                  test_end,
  output int                    pending,
  output int                    tests_passed,
  output int                    tests_failed
);

  localparam int latency       = 3;
  localparam int stall_capacity = 3;

  logic [op_width-1:0]   a_queue [$];
  logic [op_width-1:0]   b_queue [$];
  int                    t_queue [$];

  int                    cycle;
  int                    test_errors;
  int                    test_products;
  int                    stall_accepts;
  int                    acc_cycle;
  logic                  seen_ready;
  logic                  held_valid;
  logic [prod_width-1:0] held_product;
  logic [prod_width-1:0] wide_a;
  logic [prod_width-1:0] wide_b;
  logic [prod_width-1:0] expected;

  function automatic string test_label(int id);
    case (id)
      1:       return "reset state";
      2:       return "corner operands";
      3:       return "back to back";
      4:       return "random handshake";
      5:       return "output stall";
      default: return "unknown";
    endcase
  endfunction

  task automatic flag_mismatch(string sig, logic [31:0] exp_val, logic [31:0] got_val);
    $display("CHECK FAILED %s: expected %h got %h", sig, exp_val, got_val);
    test_errors++;
  endtask

  task automatic flag_problem(string msg);
    $display("Error in test %0d: %s", test_id, msg);
    test_errors++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      a_queue.delete();
      b_queue.delete();
      t_queue.delete();
      cycle         = 0;
      test_errors   = 0;
      test_products = 0;
      stall_accepts = 0;
      seen_ready    = 1'b0;
      held_valid    = 1'b0;
      pending       = 0;
      tests_passed  = 0;
      tests_failed  = 0;
    end else begin
      cycle = cycle + 1;

      // Idle pipeline straight after reset
      if (test_id == 1) begin
        if (out_valid !== 1'b0) flag_mismatch("out_valid", 0, out_valid);
        if (in_ready !== 1'b1) flag_mismatch("in_ready", 1, in_ready);
      end

      // A stalled product must hold
      if (held_valid) begin
        if (!out_valid) begin
          flag_problem("out_valid dropped while the sink was stalling");
        end else if (out_product !== held_product) begin
          flag_mismatch("out_product", held_product, out_product);
        end
      end

      //////////////////////////////
      // Delivered products

      if (out_valid && out_ready) begin
        test_products++;
        if (a_queue.size() == 0) begin
          flag_problem("a product was delivered with no accepted operands pending");
        end else begin
          wide_a    = a_queue.pop_front();
          wide_b    = b_queue.pop_front();
          acc_cycle = t_queue.pop_front();
          expected  = wide_a * wide_b;
          if (out_product !== expected) begin
            $display("CHECK FAILED out_product: a=%h b=%h expected %h got %h",
                     wide_a[op_width-1:0], wide_b[op_width-1:0], expected, out_product);
            test_errors++;
          end
          if (test_id == 3 && cycle - acc_cycle != latency) begin
            flag_mismatch("latency", latency, cycle - acc_cycle);
          end
        end
      end

      //////////////////////////////
      // Accepted operands

      // Sink always ready, so every offered pair must go in
      if (test_id == 3 && in_valid && !in_ready) begin
        flag_problem("in_ready dropped during back-to-back transfers");
      end

      if (in_valid && in_ready) begin
        a_queue.push_back(in_a);
        b_queue.push_back(in_b);
        t_queue.push_back(cycle);
        if (test_id == 5 && !seen_ready && !out_ready) stall_accepts++;
      end
      if (out_ready) seen_ready = 1'b1;

      held_valid   = out_valid && !out_ready;
      held_product = out_product;

      if (test_end) begin
        if (test_id == 5 && stall_accepts != stall_capacity) begin
          flag_problem($sformatf("%0d pairs were accepted while the output stalled, not %0d",
                                 stall_accepts, stall_capacity));
        end
        if (a_queue.size() != 0) flag_problem("products were still pending at the end of the test");
        $display("test %0d (%s): %0d products, %0d errors",
                 test_id, test_label(test_id), test_products, test_errors);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        test_errors   = 0;
        test_products = 0;
        stall_accepts = 0;
        seen_ready    = 1'b0;
      end

      pending = a_queue.size();
    end
  end

endmodule

//--- testbench/tb_mult_16x16.sv
`timescale 1ns/1ps

module tb_mult_16x16 import dadda_pkg::*; ();

  localparam logic [31:0] seed  = 32'h91894872;
  localparam int num_tests       = 5;
  localparam int num_corner      = 25 + op_width * op_width;
  localparam int num_random      = 1000;
  localparam int num_stall       = 10;
  localparam int stall_cycles    = 10;
  localparam int total_transfers = num_corner + 2 * num_random + num_stall;
  localparam int timeout_cycles  = 4 * total_transfers + 200;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  logic [op_width-1:0]   in_a;
  logic [op_width-1:0]   in_b;
  logic                  out_valid;
  logic                  out_ready;
  logic [prod_width-1:0] out_product;

  int                    test_id;
  logic                  test_end;
  int                    pending;
  int                    tests_passed;
  int                    tests_failed;
  string                 cur_test;
  logic                  accepted;
  logic                  random_ready;
  int                    cycle_count;

  mult_16x16 i_mult_16x16 (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_product(out_product)
  );

  mult_checker i_mult_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_a        (in_a),
    .in_b        (in_b),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_product (out_product),
    .test_id     (test_id),
    .test_end    (test_end),
    .pending     (pending),
    .tests_passed(tests_passed),
    .tests_failed(tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: test %0d (%s) hung, no finish after %0d cycles",
             test_id, cur_test, cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [op_width-1:0] corner_value(int k);
    case (k)
      0:       return '0;
      1:       return 1;
      2:       return '1;
      3:       return {(op_width/2){2'b10}};
      default: return {(op_width/2){2'b01}};
    endcase
  endfunction

  //////////////////////////////
  // Drive helpers

  // Inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    accepted = in_valid && in_ready;
    #1;
    if (random_ready) out_ready = $urandom % 2;
  endtask

  task automatic send(input logic [op_width-1:0] a, input logic [op_width-1:0] b);
    in_valid = 1'b1;
    in_a     = a;
    in_b     = b;
    accepted = 1'b0;
    while (!accepted) tick();
  endtask

  task automatic start_test(input int id, input string name);
    test_id  = id;
    cur_test = name;
  endtask

  task automatic end_test();
    in_valid     = 1'b0;
    random_ready = 1'b0;
    out_ready    = 1'b1;
    while (pending != 0 || out_valid) tick();
    test_end = 1'b1;
    tick();
    test_end = 1'b0;
  endtask

  initial begin
    int          sent;
    void'($urandom(seed));
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_a         = '0;
    in_b         = '0;
    out_ready    = 1'b0;
    test_id      = 0;
    test_end     = 1'b0;
    random_ready = 1'b0;
    cur_test     = "reset";
    accepted     = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test(1, "reset state");
    repeat (4) tick();
    end_test();

    start_test(2, "corner operands");
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) send(corner_value(i), corner_value(j));
    end
    for (int i = 0; i < op_width; i++) begin
      for (int j = 0; j < op_width; j++) send(1 << i, 1 << j);
    end
    end_test();

    start_test(3, "back to back");
    for (int n = 0; n < num_random; n++) send($urandom, $urandom);
    end_test();

    start_test(4, "random handshake");
    random_ready = 1'b1;
    out_ready    = $urandom % 2;
    for (int n = 0; n < num_random; n++) begin
      while ($urandom % 2) begin
        in_valid = 1'b0;
        tick();
      end
      send($urandom, $urandom);
    end
    end_test();

    // Sink stalls while the source keeps offering pairs
    start_test(5, "output stall");
    out_ready = 1'b0;
    in_valid  = 1'b1;
    in_a      = $urandom;
    in_b      = $urandom;
    sent      = 0;
    for (int c = 0; c < stall_cycles; c++) begin
      tick();
      if (accepted) begin
        sent++;
        in_a = $urandom;
        in_b = $urandom;
      end
    end
    out_ready = 1'b1;
    while (sent < num_stall) begin
      tick();
      if (accepted) begin
        sent++;
        in_a = $urandom;
        in_b = $urandom;
      end
    end
    end_test();

    $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && tests_passed == num_tests) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
